/* flist.f */
rtl/conv_cfg_pkg.sv
rtl/conv_types_pkg.sv
rtl/coef_loader.sv
rtl/window_gen.sv
rtl/mult_stage.sv
rtl/sum_stage.sv
rtl/conv_layer_top.sv
testbench/conv_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module conv_tb -Mdir obj_dir

sim_out=$(./obj_dir/Vconv_tb)
echo "$sim_out"

if echo "$sim_out" | grep -q 'All tests passed!'
then
	exit 0
fi
exit 1

/* testbench/conv_tb.sv */
`timescale 1ns/1ns

module conv_tb;

	import conv_cfg_pkg::*;
	import conv_types_pkg::*;

	localparam int N_COEF = N_WEIGHTS + C_OUT;
	localparam int N_FRAMES = 2;
	localparam int N_PIX = N_FRAMES * IMG_W * IMG_H;
	localparam int N_RES = N_FRAMES * OUT_W * OUT_H;
	// 38 coefficients and 128 pixels need a few hundred cycles at these stall rates
	localparam int MAX_CYCLES = 3000;

	logic clk;
	logic rst;
	logic coef_valid;
	logic signed [COEF_W-1:0] coef_word;
	logic coef_ready;
	logic pix_valid;
	pixel_t pix_data;
	logic pix_ready;
	logic out_valid;
	res_beat_t out_beat;
	logic out_ready;

	logic [15:0] lfsr_state;
	logic [COEF_W-1:0] coef_mem [N_COEF];
	pixel_t pix_mem [N_PIX];
	res_beat_t exp_mem [N_RES];
	res_beat_t exp_beat;
	int coef_count;
	int rcv_count;
	logic coef_fire;
	logic pix_fire;
	int idx;
	int cycles;
	int value_errs = 0;
	int proto_errs = 0;

	conv_layer_top dut_i (.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// galois lfsr stepped once per bit taken
	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] bits;
		logic lsb;
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			lsb = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (lsb)
				lfsr_state = lfsr_state ^ 16'hB400;
			bits = {bits[14:0], lsb};
		end
		return bits;
	endfunction

	// direct 3x3 convolution over both frames in raster order
	task automatic build_expected();
		int acc;
		int f;
		int r;
		int c;
		int base;
		int px;
		int wt;
		for (int n = 0; n < N_RES; n++)
		begin
			f = n / (OUT_W * OUT_H);
			r = (n / OUT_W) % OUT_H;
			c = n % OUT_W;
			base = f * IMG_W * IMG_H + r * IMG_W + c;
			for (int o = 0; o < C_OUT; o++)
			begin
				acc = int'($signed(coef_mem[N_WEIGHTS + o]));
				for (int ky = 0; ky < K; ky++)
					for (int kx = 0; kx < K; kx++)
						for (int ch = 0; ch < C_IN; ch++)
						begin
							px = int'($signed(pix_mem[base + ky * IMG_W + kx][ch]));
							wt = int'($signed(coef_mem[o * TAPS + (ky * K + kx) * C_IN + ch]));
							acc += px * wt;
						end
				exp_mem[n].res[o] = ACC_W'(acc);
			end
			exp_mem[n].pos.row = POS_W'(r);
			exp_mem[n].pos.col = POS_W'(c);
			exp_mem[n].pos.last = (r == OUT_H - 1) && (c == OUT_W - 1);
		end
	endtask

	task automatic report_value(input string name, input logic [47:0] exp,
		input logic [47:0] act);
		value_errs++;
		$display("ERROR time %0t %s expected %0h actual %0h", $time, name, exp, act);
	endtask

	task automatic report_protocol(input string msg);
		proto_errs++;
		$display("ERROR time %0t %s", $time, msg);
	endtask

	assign exp_beat = (rcv_count < N_RES) ? exp_mem[rcv_count] : '0;

	always @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			coef_count <= 0;
			rcv_count <= 0;
			coef_fire <= 1'b0;
			pix_fire <= 1'b0;
		end
		else
		begin
			coef_fire <= coef_valid && coef_ready;
			pix_fire <= pix_valid && pix_ready;
			if (coef_valid && coef_ready)
				coef_count <= coef_count + 1;
			if (out_valid && out_ready)
				rcv_count <= rcv_count + 1;
		end
	end

	idle_check: assert property (@(posedge clk) disable iff (rst)
		(coef_count < N_COEF) |-> !pix_ready && !out_valid)
		else report_protocol("pixel stream or result active before all coefficients loaded");
	loaded_check: assert property (@(posedge clk) disable iff (rst)
		(coef_count == N_COEF) |-> !coef_ready)
		else report_protocol("coef_ready still high after the last bias");
	res_check: assert property (@(posedge clk) disable iff (rst)
		out_valid && out_ready |-> out_beat.res == exp_beat.res)
		else report_value("out_beat.res", $sampled(exp_beat.res), $sampled(out_beat.res));
	pos_check: assert property (@(posedge clk) disable iff (rst)
		out_valid && out_ready |-> out_beat.pos == exp_beat.pos)
		else report_value("out_beat.pos", 48'($sampled(exp_beat.pos)),
			48'($sampled(out_beat.pos)));
	hold_check: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_beat))
		else report_protocol("stalled result was dropped or changed before out_ready");
	count_check: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> rcv_count < N_RES)
		else report_protocol("more results than two frames can produce");

	initial
	begin
		cycles = 0;
		while (cycles < MAX_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, only %0d of %0d results arrived",
			MAX_CYCLES, rcv_count, N_RES);
		$display("value errors: %0d, protocol errors: %0d", value_errs, proto_errs);
		$display("Test failures found");
		$finish;
	end

	initial
	begin
		rst = 1'b1;
		coef_valid = 1'b0;
		coef_word = '0;
		pix_valid = 1'b0;
		pix_data = '0;
		out_ready = 1'b1;
		lfsr_state = 16'd55;
		for (int i = 0; i < N_COEF; i++)
			coef_mem[i] = COEF_W'(take_bits(COEF_W));
		for (int i = 0; i < N_PIX; i++)
			pix_mem[i] = pixel_t'(take_bits(C_IN * PIX_W));
		build_expected();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		idx = 0;
		coef_valid = 1'b1;
		// first pixel waits at the input while coefficients load
		pix_valid = 1'b1;
		pix_data = pix_mem[0];
		while (idx < N_COEF)
		begin
			coef_word = coef_mem[idx];
			@(negedge clk);
			if (coef_fire)
				idx++;
		end
		coef_valid = 1'b0;

		// both frames back to back with random gaps and output stalls
		idx = 0;
		while (idx < N_PIX)
		begin
			out_ready = (take_bits(2) != 16'd0);
			if (!pix_valid && take_bits(1) == 16'd1)
			begin
				pix_valid = 1'b1;
				pix_data = pix_mem[idx];
			end
			@(negedge clk);
			if (pix_fire)
			begin
				pix_valid = 1'b0;
				idx++;
			end
		end

		while (rcv_count < N_RES)
		begin
			out_ready = (take_bits(2) != 16'd0);
			@(negedge clk);
		end
		out_ready = 1'b1;
		repeat (4) @(negedge clk);
		$display("value errors: %0d, protocol errors: %0d", value_errs, proto_errs);
		if (value_errs == 0 && proto_errs == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* rtl/conv_layer_top.sv */
`timescale 1ns/1ns

module conv_layer_top
(
	input  logic clk,
	input  logic rst,
	input  logic coef_valid,
	input  logic signed [conv_cfg_pkg::COEF_W-1:0] coef_word,
	output logic coef_ready,
	input  logic pix_valid,
	input  conv_types_pkg::pixel_t pix_data,
	output logic pix_ready,
	output logic out_valid,
	output conv_types_pkg::res_beat_t out_beat,
	input  logic out_ready
);

	import conv_types_pkg::*;

	coef_set_t coef_set;
	logic loaded;
	logic wg_in_valid;
	logic wg_in_ready;
	logic win_valid;
	logic win_ready;
	win_beat_t win_beat;
	logic prod_valid;
	logic prod_ready;
	prod_beat_t prod_beat;

	// pixel stream held off until all coefficients are in
	assign wg_in_valid = pix_valid && loaded;
	assign pix_ready = wg_in_ready && loaded;

	coef_loader coef_loader_i
	(
		.clk(clk),
		.rst(rst),
		.coef_valid(coef_valid),
		.coef_word(coef_word),
		.coef_ready(coef_ready),
		.coef_set(coef_set),
		.loaded(loaded)
	);

	window_gen window_gen_i
	(
		.clk(clk),
		.rst(rst),
		.in_valid(wg_in_valid),
		.in_pixel(pix_data),
		.in_ready(wg_in_ready),
		.out_valid(win_valid),
		.out_beat(win_beat),
		.out_ready(win_ready)
	);

	mult_stage mult_stage_i
	(
		.clk(clk),
		.rst(rst),
		.in_valid(win_valid),
		.in_beat(win_beat),
		.in_ready(win_ready),
		.coef_set(coef_set),
		.out_valid(prod_valid),
		.out_beat(prod_beat),
		.out_ready(prod_ready)
	);

	sum_stage sum_stage_i
	(
		.clk(clk),
		.rst(rst),
		.in_valid(prod_valid),
		.in_beat(prod_beat),
		.in_ready(prod_ready),
		.coef_set(coef_set),
		.out_valid(out_valid),
		.out_beat(out_beat),
		.out_ready(out_ready)
	);

endmodule

/* rtl/sum_stage.sv */
`timescale 1ns/1ns

module sum_stage
(
	input  logic clk,
	input  logic rst,
	input  logic in_valid,
	input  conv_types_pkg::prod_beat_t in_beat,
	output logic in_ready,
	input  conv_types_pkg::coef_set_t coef_set,
	output logic out_valid,
	output conv_types_pkg::res_beat_t out_beat,
	input  logic out_ready
);

	import conv_cfg_pkg::*;
	import conv_types_pkg::*;

	result_t sum_d;

	assign in_ready = !out_valid || out_ready;

	// bias plus all taps, every term sign-extended to ACC_W
	always_comb
	begin
		for (int o = 0; o < C_OUT; o++)
		begin
			sum_d[o] = ACC_W'($signed(coef_set.bias[o]));
			for (int t = 0; t < TAPS; t++)
			begin
				sum_d[o] = sum_d[o] + ACC_W'($signed(in_beat.prod[o][t]));
			end
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			out_valid <= 1'b0;
		end
		else if (in_ready)
		begin
			out_valid <= in_valid;
		end
	end

	// result register
	always_ff @(posedge clk)
	begin
		if (in_valid && in_ready)
		begin
			out_beat.res <= sum_d;
			out_beat.pos <= in_beat.pos;
		end
	end

endmodule

/* rtl/mult_stage.sv */
`timescale 1ns/1ns

module mult_stage
(
	input  logic clk,
	input  logic rst,
	input  logic in_valid,
	input  conv_types_pkg::win_beat_t in_beat,
	output logic in_ready,
	input  conv_types_pkg::coef_set_t coef_set,
	output logic out_valid,
	output conv_types_pkg::prod_beat_t out_beat,
	input  logic out_ready
);

	import conv_cfg_pkg::*;
	import conv_types_pkg::*;

	prod_arr_t prod_d;

	assign in_ready = !out_valid || out_ready;

	// tap t splits into ky, kx and input channel, same nesting as the weights
	for (genvar o = 0; o < C_OUT; o++)
	begin : g_out
		for (genvar t = 0; t < TAPS; t++)
		begin : g_tap
			assign prod_d[o][t] =
				$signed(in_beat.win[t / (K * C_IN)][(t / C_IN) % K][t % C_IN])
				* $signed(coef_set.weights[o * TAPS + t]);
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			out_valid <= 1'b0;
		end
		else if (in_ready)
		begin
			out_valid <= in_valid;
		end
	end

	// products and tag
	always_ff @(posedge clk)
	begin
		if (in_valid && in_ready)
		begin
			out_beat.prod <= prod_d;
			out_beat.pos <= in_beat.pos;
		end
	end

endmodule

/* rtl/window_gen.sv */
`timescale 1ns/1ns

module window_gen
(
	input  logic clk,
	input  logic rst,
	input  logic in_valid,
	input  conv_types_pkg::pixel_t in_pixel,
	output logic in_ready,
	output logic out_valid,
	output conv_types_pkg::win_beat_t out_beat,
	input  logic out_ready
);

	import conv_cfg_pkg::*;
	import conv_types_pkg::*;

	// previous row and the row before it
	pixel_t line1 [IMG_W];
	pixel_t line2 [IMG_W];

	logic [POS_W-1:0] col;
	logic [POS_W-1:0] row;
	logic accept;
	logic win_done;
	logic frame_end;

	assign in_ready = !out_valid || out_ready;
	assign accept = in_valid && in_ready;

	// full 3x3 neighbourhood inside the current frame
	assign win_done = (row >= POS_W'(K - 1)) && (col >= POS_W'(K - 1));
	assign frame_end = (row == POS_W'(IMG_H - 1)) && (col == POS_W'(IMG_W - 1));

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			col <= '0;
			row <= '0;
			out_valid <= 1'b0;
		end
		else
		begin
			if (in_ready)
			begin
				out_valid <= accept && win_done;
			end
			if (accept)
			begin
				if (col == POS_W'(IMG_W - 1))
				begin
					col <= '0;
					if (row == POS_W'(IMG_H - 1))
					begin
						row <= '0;
					end
					else
					begin
						row <= row + 1'b1;
					end
				end
				else
				begin
					col <= col + 1'b1;
				end
			end
		end
	end

	// line shift registers, window shift and position tag
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			line1[0] <= in_pixel;
			line2[0] <= line1[IMG_W-1];
			for (int i = 1; i < IMG_W; i++)
			begin
				line1[i] <= line1[i-1];
				line2[i] <= line2[i-1];
			end

			// columns move left, newest column enters at kx = K-1
			for (int ky = 0; ky < K; ky++)
			begin
				for (int kx = 0; kx < K - 1; kx++)
				begin
					out_beat.win[ky][kx] <= out_beat.win[ky][kx+1];
				end
			end
			out_beat.win[0][K-1] <= line2[IMG_W-1];
			out_beat.win[1][K-1] <= line1[IMG_W-1];
			out_beat.win[K-1][K-1] <= in_pixel;

			out_beat.pos.row <= row - POS_W'(K - 1);
			out_beat.pos.col <= col - POS_W'(K - 1);
			out_beat.pos.last <= frame_end;
		end
	end

endmodule

/* rtl/coef_loader.sv */
`timescale 1ns/1ns

module coef_loader
(
	input  logic clk,
	input  logic rst,
	input  logic coef_valid,
	input  logic signed [conv_cfg_pkg::COEF_W-1:0] coef_word,
	output logic coef_ready,
	output conv_types_pkg::coef_set_t coef_set,
	output logic loaded
);

	import conv_cfg_pkg::*;
	import conv_types_pkg::*;

	load_state_e state;
	logic [COEF_IDX_W-1:0] idx;
	logic accept;
	logic last_weight;
	logic last_bias;

	assign coef_ready = (state != LOADED);
	assign loaded = (state == LOADED);
	assign accept = coef_valid && coef_ready;
	assign last_weight = (idx == COEF_IDX_W'(N_WEIGHTS - 1));
	assign last_bias = (idx == COEF_IDX_W'(C_OUT - 1));

	// weights first, then one bias per output channel
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= LOAD_WEIGHTS;
			idx <= '0;
		end
		else if (accept)
		begin
			case (state)
				LOAD_WEIGHTS:
				begin
					if (last_weight)
					begin
						idx <= '0;
						state <= LOAD_BIAS;
					end
					else
					begin
						idx <= idx + 1'b1;
					end
				end
				LOAD_BIAS:
				begin
					if (last_bias)
					begin
						idx <= '0;
						state <= LOADED;
					end
					else
					begin
						idx <= idx + 1'b1;
					end
				end
				default:
				begin
					idx <= '0;
				end
			endcase
		end
	end

	// coefficient store
	always_ff @(posedge clk)
	begin
		if (accept && state == LOAD_WEIGHTS)
		begin
			coef_set.weights[idx] <= coef_word;
		end
		if (accept && state == LOAD_BIAS)
		begin
			coef_set.bias[idx[BIAS_IDX_W-1:0]] <= coef_word;
		end
	end

endmodule

/* rtl/conv_types_pkg.sv */
package conv_types_pkg;

	import conv_cfg_pkg::*;

	// one sample per input channel, each read as signed
	typedef logic [C_IN-1:0][PIX_W-1:0] pixel_t;

	// indexed [ky][kx], ky 0 is the oldest row
	typedef pixel_t [K-1:0][K-1:0] window_t;

	typedef struct packed {
		logic [POS_W-1:0] row;
		logic [POS_W-1:0] col;
		logic last;
	} pos_t;

	typedef struct packed {
		window_t win;
		pos_t pos;
	} win_beat_t;

	// tap index runs ky, kx, then input channel
	typedef logic [C_OUT-1:0][TAPS-1:0][PROD_W-1:0] prod_arr_t;

	typedef struct packed {
		prod_arr_t prod;
		pos_t pos;
	} prod_beat_t;

	typedef logic [C_OUT-1:0][ACC_W-1:0] result_t;

	typedef struct packed {
		result_t res;
		pos_t pos;
	} res_beat_t;

	// weights in stream order, bias widened to ACC_W where it is added
	typedef struct packed {
		logic [N_WEIGHTS-1:0][COEF_W-1:0] weights;
		logic [C_OUT-1:0][COEF_W-1:0] bias;
	} coef_set_t;

	typedef enum logic [1:0] {
		LOAD_WEIGHTS,
		LOAD_BIAS,
		LOADED
	} load_state_e;

endpackage

/* rtl/conv_cfg_pkg.sv */
package conv_cfg_pkg;

	// input frame
	localparam int IMG_W = 8;
	localparam int IMG_H = 8;

	// kernel side
	localparam int K = 3;

	// valid windows only
	localparam int OUT_W = IMG_W - 2;
	localparam int OUT_H = IMG_H - 2;

	localparam int C_IN = 2;
	localparam int C_OUT = 2;

	// products per output channel
	localparam int TAPS = K * K * C_IN;
	localparam int N_WEIGHTS = C_OUT * TAPS;

	// signed sample and coefficient widths
	localparam int PIX_W = 8;
	localparam int COEF_W = 8;

	// full product of one sample and one weight
	localparam int PROD_W = PIX_W + COEF_W;

	// 18 products plus bias fit with room to spare
	localparam int ACC_W = 24;

	// row and column index
	localparam int POS_W = 3;

	// coefficient store addressing
	localparam int COEF_IDX_W = $clog2(N_WEIGHTS);
	localparam int BIAS_IDX_W = $clog2(C_OUT);

endpackage
